//--- rv_core.f
+incdir+hw
+incdir+verif
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_core.sv
verif/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rv_core testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_core_tb -Mdir obj_dir -o rv_core_sim -f rv_core.f \
  && ./obj_dir/rv_core_sim 2>&1 | tee sim.log \
  || echo "build or simulation exited with an error"

grep -qx "TESTBENCH PASSED" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

//--- verif/rv_core_tb_table.svh
/*
 * program table for the rv32i core testbench
 * one call per executed step: pc, instruction word, rd and expected write data
 */
`ifndef RV_CORE_TB_TABLE_SVH
`define RV_CORE_TB_TABLE_SVH

task automatic load_program();
  // lui and the register-immediate group
  add_write_step('h00, encode_u('h12345, 1), 1, 32'h1234_5000);
  add_write_step('h04, encode_i(-1, 0, 0, 2), 2, 32'hFFFF_FFFF);
  add_write_step('h08, encode_i('h7FF, 0, 0, 3), 3, 32'h0000_07FF);
  add_write_step('h0C, encode_i('h678, 1, 0, 4), 4, 32'h1234_5678);
  add_write_step('h10, encode_i(0, 2, 2, 5), 5, 32'h1);         // slti, negative rs1
  add_write_step('h14, encode_i(1, 2, 3, 6), 6, 32'h0);         // sltiu, all ones
  add_write_step('h18, encode_i(-1, 0, 3, 7), 7, 32'h1);
  add_write_step('h1C, encode_i(-5, 3, 2, 8), 8, 32'h0);
  add_write_step('h20, encode_i(-1, 4, 4, 9), 9, 32'hEDCB_A987);
  add_write_step('h24, encode_i(-2048, 3, 6, 10), 10, 32'hFFFF_FFFF);
  add_write_step('h28, encode_i('hF0, 4, 7, 11), 11, 32'h0000_0070);
  add_write_step('h2C, encode_i(4, 4, 1, 12), 12, 32'h2345_6780);
  add_write_step('h30, encode_i(8, 9, 5, 13), 13, 32'h00ED_CBA9);     // srli
  add_write_step('h34, encode_i('h408, 9, 5, 14), 14, 32'hFFED_CBA9); // srai
  // x0 target, later read back as zero
  add_write_step('h38, encode_i(1, 4, 0, 0), 0, 32'h1234_5679);

  // register-register group
  add_write_step('h3C, encode_r(0, 3, 4, 0, 15), 15, 32'h1234_5E77);
  add_write_step('h40, encode_r('h20, 4, 3, 0, 16), 16, 32'hEDCB_B187);
  add_write_step('h44, encode_i(36, 0, 0, 17), 17, 32'h0000_0024);
  add_write_step('h48, encode_r(0, 17, 4, 1, 18), 18, 32'h2345_6780);
  add_write_step('h4C, encode_r(0, 17, 9, 5, 19), 19, 32'h0EDC_BA98);
  add_write_step('h50, encode_r('h20, 17, 9, 5, 20), 20, 32'hFEDC_BA98);
  add_write_step('h54, encode_r(0, 3, 2, 2, 21), 21, 32'h1);
  add_write_step('h58, encode_r(0, 3, 2, 3, 22), 22, 32'h0);
  add_write_step('h5C, encode_r(0, 9, 4, 4, 23), 23, 32'hFFFF_FFFF);
  add_write_step('h60, encode_r(0, 12, 11, 6, 24), 24, 32'h2345_67F0);
  add_write_step('h64, encode_r(0, 15, 9, 7, 25), 25, 32'h0000_0807);
  add_write_step('h68, encode_r(0, 3, 0, 0, 26), 26, 32'h0000_07FF);

  // each branch kind taken and not taken
  add_plain_step('h6C, encode_b('h100, 4, 3, 0));
  add_plain_step('h70, encode_b(8, 18, 12, 0));
  add_plain_step('h78, encode_b(8, 18, 12, 1));
  add_plain_step('h7C, encode_b(12, 3, 2, 1));
  add_plain_step('h88, encode_b(8, 3, 2, 4));
  add_plain_step('h90, encode_b(8, 2, 3, 4));
  add_plain_step('h94, encode_b(8, 2, 3, 5));
  add_plain_step('h9C, encode_b(8, 3, 2, 5));
  add_plain_step('hA0, encode_b(8, 2, 3, 6));
  add_plain_step('hA8, encode_b(8, 3, 2, 6));
  add_plain_step('hAC, encode_b(16, 3, 2, 7));
  add_plain_step('hBC, encode_b(8, 2, 3, 7));

  // two-pass loop closed by a backward bne
  add_write_step('hC0, encode_i(1, 27, 0, 27), 27, 32'h1);
  add_write_step('hC4, encode_i(2, 27, 2, 28), 28, 32'h1);
  add_plain_step('hC8, encode_b(-8, 0, 28, 1));
  add_write_step('hC0, encode_i(1, 27, 0, 27), 27, 32'h2);
  add_write_step('hC4, encode_i(2, 27, 2, 28), 28, 32'h0);
  add_plain_step('hC8, encode_b(-8, 0, 28, 1));

  // unknown opcode, mul and ebreak, then x29 still reads zero
  add_illegal_step('hCC, 32'hFFFF_FFFF);
  add_illegal_step('hD0, encode_r(1, 3, 4, 0, 29));
  add_illegal_step('hD4, 32'h0010_0073);
  add_write_step('hD8, encode_r(0, 4, 29, 0, 30), 30, 32'h1234_5678);

  add_random_addi('hDC, num_random, 31);

  // ecall right after the random block, then the core stays halted
  add_plain_step('hFC, 32'h0000_0073);
  for (int k = 0; k < 5; k++) begin
    add_halted_step('hFC, encode_i(1, 1, 0, 1));
  end
endtask

`endif

//--- verif/rv_core_tb.sv
/*
 * testbench for the single-cycle rv32i core
 * table-driven instruction stream with pc, halt and retire checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core_tb
  import rv_pkg::*;
();

  // major opcodes as the isa defines them
  localparam logic [6:0] isa_lui    = 7'b0110111;
  localparam logic [6:0] isa_op_imm = 7'b0010011;
  localparam logic [6:0] isa_op     = 7'b0110011;
  localparam logic [6:0] isa_branch = 7'b1100011;

  localparam int reset_cycles  = 16;
  localparam int margin_cycles = 20;
  localparam int num_random    = 8;
  localparam int clk_period_ns = 100;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] insn;
  rv_retire_t          retire;
  logic                halt;

  rv_retire_t steps [$];
  int         seed;
  int         cur_step;
  logic       table_ready;

  rv_core u_rv_core (
    .clk    (clk),
    .rst    (rst),
    .pc     (pc),
    .insn   (insn),
    .retire (retire),
    .halt   (halt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] encode_i(input int imm, input int rs1, input int f3,
                                           input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], isa_op_imm};
  endfunction

  function automatic logic [31:0] encode_r(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], isa_op};
  endfunction

  // offset is the byte distance from the branch itself
  function automatic logic [31:0] encode_b(input int off, input int rs2, input int rs1,
                                           input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], isa_branch};
  endfunction

  function automatic logic [31:0] encode_u(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], isa_lui};
  endfunction

  task automatic add_write_step(input logic [31:0] at_pc, input logic [31:0] word,
                                input int rd, input logic [31:0] wdata);
    rv_retire_t rec;
    rec           = '0;
    rec.valid     = 1'b1;
    rec.pc        = at_pc;
    rec.insn      = word;
    rec.reg_write = 1'b1;
    rec.rd        = rd[4:0];
    rec.wdata     = wdata;
    steps.push_back(rec);
  endtask

  // branches and ecall retire without a register write
  task automatic add_plain_step(input logic [31:0] at_pc, input logic [31:0] word);
    rv_retire_t rec;
    rec       = '0;
    rec.valid = 1'b1;
    rec.pc    = at_pc;
    rec.insn  = word;
    steps.push_back(rec);
  endtask

  task automatic add_illegal_step(input logic [31:0] at_pc, input logic [31:0] word);
    rv_retire_t rec;
    rec         = '0;
    rec.valid   = 1'b1;
    rec.pc      = at_pc;
    rec.insn    = word;
    rec.illegal = 1'b1;
    steps.push_back(rec);
  endtask

  task automatic add_halted_step(input logic [31:0] at_pc, input logic [31:0] word);
    rv_retire_t rec;
    rec      = '0;
    rec.pc   = at_pc;
    rec.insn = word;
    steps.push_back(rec);
  endtask

  // chain of addi on one register, expected sum kept here
  task automatic add_random_addi(input logic [31:0] first_pc, input int count, input int rd);
    int          rnd;
    logic [11:0] imm;
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < count; k++) begin
      rnd = $random(seed);
      imm = rnd[11:0];
      acc = acc + {{20{imm[11]}}, imm};
      add_write_step(first_pc + 4 * k, encode_i({20'b0, imm}, rd, 0, rd), rd, acc);
    end
  endtask

  `include "rv_core_tb_table.svh"

  task automatic expect_equal(input string name, input logic [31:0] want,
                              input logic [31:0] got);
    assert (got === want) else begin
      $display("Mismatch %s at step %0d: expected 0x%08h, got 0x%08h",
               name, cur_step, want, got);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic run_step(input int idx);
    rv_retire_t want;
    want     = steps[idx];
    cur_step = idx;
    expect_equal("pc", want.pc, pc);
    expect_equal("halt", {31'b0, !want.valid}, {31'b0, halt});
    insn = want.insn;
    #10;
    expect_equal("retire.valid", {31'b0, want.valid}, {31'b0, retire.valid});
    expect_equal("retire.pc", want.pc, retire.pc);
    expect_equal("retire.insn", want.insn, retire.insn);
    expect_equal("retire.reg_write", {31'b0, want.reg_write}, {31'b0, retire.reg_write});
    expect_equal("retire.rd", {27'b0, want.rd}, {27'b0, retire.rd});
    expect_equal("retire.wdata", want.wdata, retire.wdata);
    expect_equal("retire.illegal", {31'b0, want.illegal}, {31'b0, retire.illegal});
  endtask

  initial begin
    rst         = 1'b1;
    insn        = '0;
    seed        = 30048;
    cur_step    = -1;
    table_ready = 1'b0;
    load_program();
    table_ready = 1'b1;

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    expect_equal("pc", `RV_RESET_PC, pc);
    expect_equal("halt", 32'h0, {31'b0, halt});
    expect_equal("retire.valid", 32'h0, {31'b0, retire.valid});
    rst = 1'b0;

    for (int i = 0; i < steps.size(); i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      run_step(i);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((steps.size() + reset_cycles + margin_cycles) * clk_period_ns);
    $display("timeout: the core did not get through the step table in time");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
/*
 * single-cycle rv32i core
 * pc and next-pc logic, writeback, ecall halt and retire trace
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] insn,
  output rv_retire_t          retire,
  output logic                halt
);

  rv_decode_t          dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                branch_taken;
  logic                consume;
  logic                reg_we;
  logic [`RV_XLEN-1:0] next_pc;

  // instruction strobe, no back-pressure
  assign consume = !rst && !halt;

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (dec.rs1),
    .rs2_idx  (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_we),
    .rd_idx   (dec.rd),
    .rd_data  (alu_result)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .a            (rs1_data),
    .b            (alu_b),
    .op           (dec.alu_op),
    .cond         (dec.cond),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  assign reg_we = consume && dec.reg_write && !dec.illegal;

  // ecall holds the pc at its own address
  always_comb begin
    if (dec.is_halt) begin
      next_pc = pc;
    end else if (dec.is_branch && branch_taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + `RV_INSN_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (consume) begin
      pc <= next_pc;
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (consume && dec.is_halt) begin
      halt <= 1'b1;
    end
  end

  always_comb begin
    retire.valid     = consume;
    retire.pc        = pc;
    retire.insn      = insn;
    retire.reg_write = reg_we;
    retire.rd        = reg_we ? dec.rd : '0;
    retire.wdata     = reg_we ? alu_result : '0;
    retire.illegal   = consume && dec.illegal;
  end

endmodule

`default_nettype wire

//--- hw/rv_alu.sv
/*
 * rv32i alu
 * arithmetic, logic, shift and compare, plus branch condition
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_alu
  import rv_pkg::*;
(
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_alu_op_e          op,
  input  rv_branch_e          cond,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic [4:0] shamt;

  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // condition on the two register operands
  always_comb begin
    case (cond)
      br_beq:  branch_taken = eq;
      br_bne:  branch_taken = !eq;
      br_blt:  branch_taken = lt_s;
      br_bge:  branch_taken = !lt_s;
      br_bltu: branch_taken = lt_u;
      br_bgeu: branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
/*
 * rv32i register file
 * two async read ports, one sync write port, x0 reads zero
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_idx,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_idx,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] rd_idx,
  input  logic [`RV_XLEN-1:0]       rd_data
);

  // x1 .. x31 only
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- hw/rv_decoder.sv
/*
 * rv32i instruction decoder
 * splits the word, forms immediates and classifies the instruction
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic [`RV_XLEN-1:0] insn,
  output rv_decode_t          dec
);

  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] shamt;

  assign opcode = rv_opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign shamt = {27'b0, insn[24:20]};

  always_comb begin
    dec           = '0;
    dec.rs1       = insn[19:15];
    dec.rs2       = insn[24:20];
    dec.rd        = insn[11:7];
    dec.imm       = imm_i;
    dec.alu_op    = alu_add;
    dec.cond      = rv_branch_e'(funct3);

    case (opcode)
      opc_lui: begin
        dec.imm       = imm_u;
        dec.alu_op    = alu_pass_b;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      opc_op_imm: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          3'b001: begin
            dec.imm     = shamt;
            dec.alu_op  = alu_sll;
            dec.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // srli / srai share funct3
            dec.imm = shamt;
            if (funct7 == 7'b0000000) begin
              dec.alu_op = alu_srl;
            end else if (funct7 == 7'b0100000) begin
              dec.alu_op = alu_sra;
            end else begin
              dec.illegal = 1'b1;
            end
          end
        endcase
      end
      opc_op: begin
        dec.reg_write = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec.alu_op = alu_add;
            3'b001:  dec.alu_op = alu_sll;
            3'b010:  dec.alu_op = alu_slt;
            3'b011:  dec.alu_op = alu_sltu;
            3'b100:  dec.alu_op = alu_xor;
            3'b101:  dec.alu_op = alu_srl;
            3'b110:  dec.alu_op = alu_or;
            default: dec.alu_op = alu_and;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op = alu_sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec.alu_op = alu_sra;
        end else begin
          // includes the M extension encodings
          dec.illegal = 1'b1;
        end
      end
      opc_branch: begin
        dec.imm       = imm_b;
        dec.alu_op    = alu_sub;
        dec.is_branch = 1'b1;
        dec.illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      opc_system: begin
        // only a bare ecall is accepted
        dec.is_halt = (insn[31:7] == 25'd0);
        dec.illegal = (insn[31:7] != 25'd0);
      end
      default: dec.illegal = 1'b1;
    endcase

    if (dec.illegal) begin
      dec.reg_write = 1'b0;
      dec.is_branch = 1'b0;
      dec.is_halt   = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
/*
 * rv32i core types
 * opcode, alu and branch enums plus the decode and retire records
 */
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011,
    opc_system = 7'b1110011
  } rv_opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } rv_alu_op_e;

  // encoded as funct3 of the branch group
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } rv_branch_e;

  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm;
    rv_alu_op_e                alu_op;
    logic                      use_imm;
    logic                      reg_write;
    logic                      is_branch;
    rv_branch_e                cond;
    logic                      is_halt;
    logic                      illegal;
  } rv_decode_t;

  // architectural effect of one executed instruction
  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       insn;
    logic                      reg_write;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       wdata;
    logic                      illegal;
  } rv_retire_t;

endpackage

`default_nettype wire

//--- hw/rv_macros.svh
/*
 * rv32i core constants
 * widths, register count and program counter stepping
 */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// register index width and count
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// pc after reset
`define RV_RESET_PC 32'h0000_0000

// bytes per instruction
`define RV_INSN_STEP 32'd4

`endif
